// File: bench/pcie_tx_tb.sv
`timescale 1ns/1ps
`default_nettype none

// Random training runs against a cycle model of sequencer, generator and scrambler
module pcie_tx_tb;

	localparam bit [7:0] TS1_N  = 8'd4;
	localparam bit [7:0] TS2_N  = 8'd3;
	localparam bit [6:0] SKIP_N = 7'd5;
	localparam int RUNS         = 30;
	localparam int RUN_WORDS    = 7 * 8 + 4 + 64;	// Sets, SKP words and idle per run
	localparam int WATCHDOG_NS  = RUNS * RUN_WORDS * 8 * 2;

	logic clk;
	logic rst_n;
	logic train_start;
	pcie_pkg::ts_fields_t ts_fields;
	pcie_pkg::tx_symbols_t tx_out;
	logic ts_sent;
	logic link_up;

	// Model state
	int m_seq;	// 0 idle, 1 TS1, 2 TS2
	int m_cnt;	// Sets in the current phase
	logic m_link_up;
	int m_pos;	// Next word of the set, 0 head, 3..7 filler, 8..9 SKP
	int m_skip;	// Sets since the last SKP
	pcie_pkg::tx_word_t m_word;
	logic m_ts_sent;
	logic [15:0] m_lfsr;
	pcie_pkg::tx_symbols_t m_tx;

	int errors = 0;
	int checks = 0;
	int skp_sets = 0;
	int link_ups = 0;
	int restarts = 0;
	logic link_prev = 1'b0;

	tb_clock #(.PERIOD_NS(8), .RESET_CYCLES(3)) u_clk (.clk(clk), .rst_n(rst_n));

	pcie_tx_top #(
		.TS1_COUNT     (TS1_N),
		.TS2_COUNT     (TS2_N),
		.SKIP_INTERVAL (SKIP_N)
	) uut (
		.clk         (clk),
		.rst_n       (rst_n),
		.train_start (train_start),
		.ts_fields   (ts_fields),
		.tx_out      (tx_out),
		.ts_sent     (ts_sent),
		.link_up     (link_up)
	);

	// One symbol through the serial LFSR, bit 0 first against the LFSR top bit
	task automatic scramble_symbol(input logic [7:0] d, input logic k, input logic os,
		inout logic [15:0] l, output logic [7:0] q);
		logic fb;
		q = d;
		if (!(k && d == pcie_pkg::sym_skp)) begin	// SKP leaves the LFSR alone
			if (k && d == pcie_pkg::sym_com)
				l = pcie_pkg::lfsr_seed;
			for (int i = 0; i < 8; i++) begin
				if (!k && !os)
					q[i] = d[i] ^ l[15];
				fb = l[15];
				l = {l[14:0], 1'b0};
				if (fb)
					l = l ^ 16'h0039;	// x^5+x^4+x^3+1 taps
			end
		end
	endtask

	// Expected word of a TS or SKP set at a given position
	function automatic pcie_pkg::tx_word_t set_word(input int pos, input logic ts2,
		input pcie_pkg::ts_fields_t f);
		pcie_pkg::tx_word_t w;
		logic [7:0] id;
		w = '0;
		w.ordered_set = 1'b1;
		id = ts2 ? pcie_pkg::sym_ts2_id : pcie_pkg::sym_ts1_id;
		case (pos)
			0: begin
				w.sym.data[7:0] = pcie_pkg::sym_com;
				w.sym.charisk[0] = 1'b1;
				w.sym.data[15:8] = f.link_valid ? {3'b000, f.link} : pcie_pkg::sym_pad;
				w.sym.charisk[1] = !f.link_valid;
			end
			1: begin
				w.sym.data[7:0] = f.lane_valid ? {3'b000, f.lane} : pcie_pkg::sym_pad;
				w.sym.charisk[0] = !f.lane_valid;
				w.sym.data[15:8] = f.num_fts;
			end
			2: w.sym.data = {8'h00, 8'h02 | {5'd0, f.rate_5g, 2'b00}};	// Rate, then control 0
			8: begin
				w.sym.data = {pcie_pkg::sym_skp, pcie_pkg::sym_com};
				w.sym.charisk = 2'b11;
			end
			9: begin
				w.sym.data = {pcie_pkg::sym_skp, pcie_pkg::sym_skp};
				w.sym.charisk = 2'b11;
			end
			default: w.sym.data = {id, id};	// Filler
		endcase
		return w;
	endfunction

	always @(posedge clk) begin : model_step
		logic en;
		logic ts2;
		logic sent_now;
		logic [15:0] l;
		logic [7:0] q0;
		logic [7:0] q1;
		if (!rst_n) begin
			m_seq = 0;
			m_cnt = 0;
			m_link_up = 1'b0;
			m_pos = 0;
			m_skip = 0;
			m_word = '0;
			m_ts_sent = 1'b0;
			m_lfsr = pcie_pkg::lfsr_seed;
			m_tx = '0;
		end else begin
			// Enable drops in the cycle of the final TS2 strobe
			en = (m_seq != 0) && !(m_ts_sent && m_seq == 2 && m_cnt == TS2_N - 1);
			ts2 = (m_seq == 2);
			sent_now = m_ts_sent;
			l = m_lfsr;
			scramble_symbol(m_word.sym.data[7:0], m_word.sym.charisk[0],
				m_word.ordered_set, l, q0);
			scramble_symbol(m_word.sym.data[15:8], m_word.sym.charisk[1],
				m_word.ordered_set, l, q1);
			m_lfsr = l;
			m_tx = {q1, q0, m_word.sym.charisk};
			m_ts_sent = 1'b0;
			if (m_pos == 0) begin
				if (en) begin
					m_word = set_word(0, ts2, ts_fields);
					m_skip++;
					m_pos = 1;
				end else begin
					m_word = '0;	// Logical idle
				end
			end else begin
				m_word = set_word(m_pos, ts2, ts_fields);
				if (m_pos == 7) begin
					m_ts_sent = 1'b1;
					m_pos = (m_skip >= SKIP_N) ? 8 : 0;
					if (m_skip >= SKIP_N)
						m_skip = 0;
				end else begin
					m_pos = (m_pos == 9) ? 0 : m_pos + 1;
				end
			end
			if (train_start) begin
				m_seq = 1;
				m_cnt = 0;
				m_link_up = 1'b0;
			end else if (sent_now) begin
				if (m_seq == 1 && m_cnt == TS1_N - 1) begin
					m_seq = 2;
					m_cnt = 0;
				end else if (m_seq == 2 && m_cnt == TS2_N - 1) begin
					m_seq = 0;
					m_cnt = 0;
					m_link_up = 1'b1;
				end else begin
					m_cnt = (m_seq == 0) ? 0 : m_cnt + 1;
				end
			end
		end
	end

	// Outputs are stable half a cycle after the edge
	always @(negedge clk) begin
		checks++;
		if (tx_out.data !== m_tx.data) begin
			errors++;
			$display("Fail %0t ns tx_out.data expected %h got %h", $time, m_tx.data,
				tx_out.data);
		end
		if (tx_out.charisk !== m_tx.charisk) begin
			errors++;
			$display("Fail %0t ns tx_out.charisk expected %b got %b", $time, m_tx.charisk,
				tx_out.charisk);
		end
		if (ts_sent !== m_ts_sent) begin
			errors++;
			$display("Fail %0t ns ts_sent expected %b got %b", $time, m_ts_sent, ts_sent);
		end
		if (link_up !== m_link_up) begin
			errors++;
			$display("Fail %0t ns link_up expected %b got %b", $time, m_link_up, link_up);
		end
		if (m_tx.charisk == 2'b11 && m_tx.data == {pcie_pkg::sym_skp, pcie_pkg::sym_com})
			skp_sets++;
		if (m_link_up && !link_prev)
			link_ups++;
		link_prev = m_link_up;
	end

	// One cycle of stimulus, fields change only at a set boundary
	task automatic next_cycle(input logic start);
		logic [31:0] r;
		@(negedge clk);
		train_start = start;
		if (start && m_seq != 0)
			restarts++;	// Restart in mid-training
		if (m_pos == 0) begin
			r = $urandom;
			ts_fields = r[20:0];
		end
	endtask

	initial begin
		int unsigned seed_val;
		int gap;
		train_start = 1'b0;
		ts_fields = '0;
		seed_val = $urandom(32'hc5c8_4b08);
		wait (rst_n === 1'b1);
		repeat (40) next_cycle(1'b0);	// Idle before the first run
		for (int run = 0; run < RUNS; run++) begin
			next_cycle(1'b1);
			if ($urandom % 4 == 0)
				gap = 10 + $urandom % 40;	// Cuts the run short
			else
				gap = 70 + $urandom % 50;
			repeat (gap) next_cycle(1'b0);
		end
		repeat (100) next_cycle(1'b0);
		@(posedge clk);
		if (skp_sets == 0) begin
			errors++;
			$display("No SKP ordered set was seen in the whole run");
		end
		if (link_ups == 0) begin
			errors++;
			$display("The link never came up");
		end
		if (restarts == 0) begin
			errors++;
			$display("No training run was restarted in mid-training");
		end
		$display("Summary: %0d checks, %0d errors, %0d SKP sets, %0d link-ups, %0d restarts",
			checks, errors, skp_sets, link_ups, restarts);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
		$display("Summary: %0d checks, %0d errors, %0d SKP sets, %0d link-ups, %0d restarts",
			checks, errors, skp_sets, link_ups, restarts);
		$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: bench/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

// Free-running clock and power-on reset for the testbench
module tb_clock #(
	parameter int PERIOD_NS    = 8,
	parameter int RESET_CYCLES = 3	// Rising edges with reset held
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;	// Released away from the active edge
	end

endmodule

`default_nettype wire

// File: src/pcie_link_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

// Training phase control for one lane
// Counts TS1 sets, then TS2 sets, then reports link-up
module pcie_link_sequencer #(
	parameter bit [7:0] TS1_COUNT = 8'd16,	// TS1 sets before switching to TS2
	parameter bit [7:0] TS2_COUNT = 8'd16	// TS2 sets before link-up
) (
	input  wire  clk,
	input  wire  rst_n,
	input  wire  train_start,	// Single-cycle request to (re)start training
	input  wire  ts_sent,	// Generator finished a set
	output logic ts_en,	// Generator may start sets
	output logic set_is_ts2,	// Filler type for the sets in progress
	output logic link_up
);

	typedef enum logic [1:0] {
		SEQ_IDLE,	// Not training, generator sends logical idle
		SEQ_TS1,
		SEQ_TS2
	} seq_state_t;

	seq_state_t state;
	logic [7:0] set_cnt;	// Sets sent in the current phase
	logic       last_ts2;	// Strobe for the final TS2 set

	assign last_ts2 = ts_sent && (state == SEQ_TS2) && (set_cnt == TS2_COUNT - 8'd1);

	// Enable drops already in the cycle of the final strobe
	// The generator samples it in HEAD on the same edge, so no extra set starts
	assign ts_en      = (state != SEQ_IDLE) && !last_ts2;
	assign set_is_ts2 = (state == SEQ_TS2);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= SEQ_IDLE;
			set_cnt <= 8'd0;
			link_up <= 1'b0;
		end else if (train_start) begin
			// Restart from TS1 even in mid-training
			state   <= SEQ_TS1;
			set_cnt <= 8'd0;
			link_up <= 1'b0;
		end else if (ts_sent) begin
			case (state)
				SEQ_TS1: begin
					if (set_cnt == TS1_COUNT - 8'd1) begin
						state   <= SEQ_TS2;	// Last TS1 set done
						set_cnt <= 8'd0;
					end else begin
						set_cnt <= set_cnt + 8'd1;
					end
				end

				SEQ_TS2: begin
					if (last_ts2) begin
						state   <= SEQ_IDLE;
						set_cnt <= 8'd0;
						link_up <= 1'b1;	// Stays up until the next train_start
					end else begin
						set_cnt <= set_cnt + 8'd1;
					end
				end

				default: begin
					// Strobe of a set still in flight after link-up, nothing to count
					set_cnt <= 8'd0;
				end
			endcase
		end
	end

	// Training and link-up are exclusive, also across a restart
	a_en_vs_link_up: assert property (@(posedge clk) disable iff (!rst_n)
		!(ts_en && link_up));

endmodule

`default_nettype wire

// File: src/pcie_pkg.sv
`default_nettype none

package pcie_pkg;

	// Special symbols, all sent with the K flag set
	localparam logic [7:0] sym_com = 8'hbc;	// K28.5, starts every ordered set
	localparam logic [7:0] sym_pad = 8'hf7;	// K23.7, stands in for an unassigned link or lane
	localparam logic [7:0] sym_skp = 8'h1c;	// K28.0

	// Training set identifier symbols, sent as data
	localparam logic [7:0] sym_ts1_id = 8'h4a;	// D10.2
	localparam logic [7:0] sym_ts2_id = 8'h45;	// D5.2

	// Scrambler LFSR value loaded on every COM
	localparam logic [15:0] lfsr_seed = 16'hffff;

	// Contents of a training set as advertised by this port
	typedef struct packed {
		logic       link_valid;	// Link number assigned
		logic [4:0] link;
		logic       lane_valid;	// Lane number assigned
		logic [4:0] lane;
		logic [7:0] num_fts;	// FTS count needed to leave L0s
		logic       rate_5g;	// Advertise 5 GT/s besides 2.5 GT/s
	} ts_fields_t;

	// Two symbols per clock, symbol 0 in the low byte goes out first
	typedef struct packed {
		logic [15:0] data;
		logic [1:0]  charisk;	// One K flag per symbol
	} tx_symbols_t;

	// Generator output word
	typedef struct packed {
		tx_symbols_t sym;
		logic        ordered_set;	// Both symbols belong to a TS or SKP set
	} tx_word_t;

endpackage

`default_nettype wire

// File: src/pcie_ts_generator.sv
`timescale 1ns/1ps
`default_nettype none

// TS1/TS2 ordered set generator with periodic SKP sets
// Sends logical idle whenever training is not enabled
module pcie_ts_generator #(
	parameter bit [6:0] SKIP_INTERVAL = 7'd80	// Training sets between SKP sets
) (
	input  wire                   clk,
	input  wire                   rst_n,
	input  wire                   ts_en,
	input  wire                   set_is_ts2,
	input  wire pcie_pkg::ts_fields_t fields,
	output pcie_pkg::tx_word_t    word,
	output logic                  ts_sent	// Last filler word of a set registered
);

	typedef enum logic [2:0] {
		GEN_HEAD,	// COM and link, or logical idle
		GEN_LANEFTS,
		GEN_RATECTL,
		GEN_FILLER,	// Five words of identifiers
		GEN_SKIP_0,
		GEN_SKIP_1
	} gen_state_t;

	gen_state_t state;
	logic [2:0] fill_cnt;	// Filler word index 0..4
	logic [6:0] skip_cnt;	// Training sets since the last SKP set

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= GEN_HEAD;
			word     <= '0;
			fill_cnt <= 3'd0;
			skip_cnt <= 7'd0;
			ts_sent  <= 1'b0;
		end else begin
			ts_sent <= 1'b0;

			case (state)
				GEN_HEAD: begin
					if (ts_en) begin
						word.sym.data[7:0]   <= pcie_pkg::sym_com;
						word.sym.charisk[0]  <= 1'b1;
						word.ordered_set     <= 1'b1;
						if (fields.link_valid) begin
							word.sym.data[15:8]  <= {3'b000, fields.link};
							word.sym.charisk[1]  <= 1'b0;
						end else begin
							word.sym.data[15:8]  <= pcie_pkg::sym_pad;	// No link number yet
							word.sym.charisk[1]  <= 1'b1;
						end
						skip_cnt <= skip_cnt + 7'd1;	// Counts sets across runs
						state    <= GEN_LANEFTS;
					end else begin
						word <= '0;	// Logical idle, scrambled downstream
					end
				end

				GEN_LANEFTS: begin
					if (fields.lane_valid) begin
						word.sym.data[7:0]  <= {3'b000, fields.lane};
						word.sym.charisk[0] <= 1'b0;
					end else begin
						word.sym.data[7:0]  <= pcie_pkg::sym_pad;
						word.sym.charisk[0] <= 1'b1;
					end
					word.sym.data[15:8] <= fields.num_fts;
					word.sym.charisk[1] <= 1'b0;
					word.ordered_set    <= 1'b1;
					state               <= GEN_RATECTL;
				end

				// Rate identifier then training control
				GEN_RATECTL: begin
					word.sym.data    <= {8'h00, 5'b00000, fields.rate_5g, 2'b10};	// 2.5G always
					word.sym.charisk <= 2'b00;
					word.ordered_set <= 1'b1;
					fill_cnt         <= 3'd0;
					state            <= GEN_FILLER;
				end

				GEN_FILLER: begin
					if (set_is_ts2)
						word.sym.data <= {pcie_pkg::sym_ts2_id, pcie_pkg::sym_ts2_id};
					else
						word.sym.data <= {pcie_pkg::sym_ts1_id, pcie_pkg::sym_ts1_id};
					word.sym.charisk <= 2'b00;
					word.ordered_set <= 1'b1;
					fill_cnt         <= fill_cnt + 3'd1;

					if (fill_cnt == 3'd4) begin	// 8th word of the set
						ts_sent <= 1'b1;
						if (skip_cnt >= SKIP_INTERVAL) begin
							skip_cnt <= 7'd0;
							state    <= GEN_SKIP_0;
						end else begin
							state    <= GEN_HEAD;
						end
					end
				end

				GEN_SKIP_0: begin
					word.sym.data    <= {pcie_pkg::sym_skp, pcie_pkg::sym_com};	// COM goes first
					word.sym.charisk <= 2'b11;
					word.ordered_set <= 1'b1;
					state            <= GEN_SKIP_1;
				end

				GEN_SKIP_1: begin
					word.sym.data    <= {pcie_pkg::sym_skp, pcie_pkg::sym_skp};
					word.sym.charisk <= 2'b11;
					word.ordered_set <= 1'b1;
					state            <= GEN_HEAD;
				end

				default: begin
					word  <= '0;
					state <= GEN_HEAD;
				end
			endcase
		end
	end

	// Completion strobe only for the last filler word of a set
	a_sent_at_end: assert property (@(posedge clk) disable iff (!rst_n)
		ts_sent |-> $past(state == GEN_FILLER && fill_cnt == 3'd4));

endmodule

`default_nettype wire

// File: src/pcie_tx_scrambler.sv
`timescale 1ns/1ps
`default_nettype none

// PCIe Gen1/Gen2 data scrambler, two symbols per clock
// LFSR x^16+x^5+x^4+x^3+1 in Galois form, one clock of latency
module pcie_tx_scrambler (
	input  wire                clk,
	input  wire                rst_n,
	input  wire pcie_pkg::tx_word_t word_in,
	output pcie_pkg::tx_symbols_t tx_out
);

	logic [15:0] lfsr_q;	// State before symbol 0
	logic [15:0] lfsr_mid;	// State before symbol 1
	logic [15:0] lfsr_nxt;	// State after both symbols
	pcie_pkg::tx_symbols_t out_nxt;

	// Eight serial shifts of the LFSR, one per symbol bit
	function automatic logic [15:0] lfsr_adv8(input logic [15:0] l);
		logic [15:0] s;
		s = l;
		for (int i = 0; i < 8; i++) begin
			if (s[15])
				s = {s[14:0], 1'b0} ^ 16'h0039;	// Taps 5, 4, 3 and 0
			else
				s = {s[14:0], 1'b0};
		end
		return s;
	endfunction

	// LFSR state after one symbol
	function automatic logic [15:0] lfsr_sym(
		input logic [15:0] l,
		input logic [7:0]  d,
		input logic        k
	);
		if (k && d == pcie_pkg::sym_com)
			return lfsr_adv8(pcie_pkg::lfsr_seed);	// COM reseeds, then counts as a symbol
		else if (k && d == pcie_pkg::sym_skp)
			return l;	// SKP is invisible to the LFSR
		else
			return lfsr_adv8(l);
	endfunction

	// Scrambled symbol, key is the top byte bit-reversed (first output bit is bit 15)
	function automatic logic [7:0] scr_sym(
		input logic [15:0] l,
		input logic [7:0]  d,
		input logic        k,
		input logic        os
	);
		logic [7:0] key;
		for (int i = 0; i < 8; i++)
			key[i] = l[15 - i];
		if (k || os)
			return d;	// K symbols and ordered sets go out in the clear
		else
			return d ^ key;
	endfunction

	always_comb begin
		lfsr_mid = lfsr_sym(lfsr_q, word_in.sym.data[7:0], word_in.sym.charisk[0]);
		lfsr_nxt = lfsr_sym(lfsr_mid, word_in.sym.data[15:8], word_in.sym.charisk[1]);

		out_nxt.data[7:0]  = scr_sym(lfsr_q, word_in.sym.data[7:0],
			word_in.sym.charisk[0], word_in.ordered_set);
		out_nxt.data[15:8] = scr_sym(lfsr_mid, word_in.sym.data[15:8],
			word_in.sym.charisk[1], word_in.ordered_set);
		out_nxt.charisk    = word_in.sym.charisk;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			lfsr_q <= pcie_pkg::lfsr_seed;
			tx_out <= '0;
		end else begin
			lfsr_q <= lfsr_nxt;
			tx_out <= out_nxt;
		end
	end

	// K flags pass through with exactly one clock of delay
	a_charisk_pass: assert property (@(posedge clk) disable iff (!rst_n)
		1'b1 |=> tx_out.charisk == $past(word_in.sym.charisk));

endmodule

`default_nettype wire

// File: src/pcie_tx_top.sv
`timescale 1ns/1ps
`default_nettype none

// Transmit side of one PCIe Gen1/Gen2 lane
// Sequencer -> training set generator -> scrambler
module pcie_tx_top #(
	parameter bit [7:0] TS1_COUNT     = 8'd16,
	parameter bit [7:0] TS2_COUNT     = 8'd16,
	parameter bit [6:0] SKIP_INTERVAL = 7'd80	// About 1280 symbol times between SKPs
) (
	input  wire                   clk,
	input  wire                   rst_n,
	input  wire                   train_start,
	input  wire pcie_pkg::ts_fields_t ts_fields,	// Sampled live by the generator
	output pcie_pkg::tx_symbols_t tx_out,	// To the 8b/10b encoder
	output logic                  ts_sent,
	output logic                  link_up
);

	logic               ts_en;
	logic               set_is_ts2;
	pcie_pkg::tx_word_t gen_word;	// Unscrambled symbols plus ordered-set flag

	// Training phase control
	pcie_link_sequencer #(
		.TS1_COUNT (TS1_COUNT),
		.TS2_COUNT (TS2_COUNT)
	) u_seq (
		.clk         (clk),
		.rst_n       (rst_n),
		.train_start (train_start),
		.ts_sent     (ts_sent),
		.ts_en       (ts_en),
		.set_is_ts2  (set_is_ts2),
		.link_up     (link_up)
	);

	// Ordered sets and logical idle
	pcie_ts_generator #(
		.SKIP_INTERVAL (SKIP_INTERVAL)
	) u_gen (
		.clk        (clk),
		.rst_n      (rst_n),
		.ts_en      (ts_en),
		.set_is_ts2 (set_is_ts2),
		.fields     (ts_fields),
		.word       (gen_word),
		.ts_sent    (ts_sent)
	);

	// Data scrambling, one clock behind the generator
	pcie_tx_scrambler u_scr (
		.clk     (clk),
		.rst_n   (rst_n),
		.word_in (gen_word),
		.tx_out  (tx_out)
	);

endmodule

`default_nettype wire

// File: verilog.f
src/pcie_pkg.sv
src/pcie_link_sequencer.sv
src/pcie_ts_generator.sv
src/pcie_tx_scrambler.sv
src/pcie_tx_top.sv
bench/tb_clock.sv
bench/pcie_tx_tb.sv
